/* hdl/key_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module key_tracker (
	input  wire                     CLOCK_50,
	input  wire                     arst_n,
	input  wire [7:0]               byte_data,
	input  wire                     byte_valid,
	output synth_pkg::voice_slots_t slots
);

	import synth_pkg::*;

	logic       break_pending;
	logic       is_note;
	logic       held;
	logic       free_found;
	logic [1:0] free_idx;
	logic       dup_code;

	assign is_note = note_half_period(byte_data) != 17'd0;

	// Lowest free slot and whether the code already sounds
	always_comb begin
		held       = 1'b0;
		free_found = 1'b0;
		free_idx   = '0;
		for (int i = NUM_VOICES - 1; i >= 0; i--) begin
			if (slots[i].active && slots[i].code == byte_data)
				held = 1'b1;
			if (!slots[i].active) begin
				free_found = 1'b1;
				free_idx   = 2'(i);
			end
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			slots         <= '0;
			break_pending <= 1'b0;
		end else if (byte_valid) begin
			if (byte_data == BREAK_PREFIX) begin
				break_pending <= 1'b1;
			end else if (break_pending) begin
				// Release whichever slot holds the key
				break_pending <= 1'b0;
				for (int i = 0; i < NUM_VOICES; i++)
					if (slots[i].active && slots[i].code == byte_data)
						slots[i].active <= 1'b0;
			end else if (is_note && !held && free_found) begin
				// Typematic repeats land on held and are ignored
				slots[free_idx].active <= 1'b1;
				slots[free_idx].code   <= byte_data;
			end
		end
	end

	// Pairwise duplicate search
	always_comb begin
		dup_code = 1'b0;
		for (int i = 0; i < NUM_VOICES; i++)
			for (int j = i + 1; j < NUM_VOICES; j++)
				if (slots[i].active && slots[j].active && slots[i].code == slots[j].code)
					dup_code = 1'b1;
	end

	a_no_dup: assert property (@(posedge CLOCK_50) disable iff (!arst_n) !dup_code);

endmodule

`default_nettype wire

/* hdl/keyboard_synth_top.sv */
`timescale 1ns/1ps
`default_nettype none

module keyboard_synth_top (
	input  wire                       CLOCK_50,
	input  wire                       arst_n,
	input  wire                       ps2_clk,
	input  wire                       ps2_dat,
	input  wire [3:0]                 tone_sel,
	input  wire synth_pkg::stereo_sample_t audio_in,
	input  wire                       audio_in_available,
	input  wire                       audio_out_allowed,
	output logic                      read_audio_in,
	output synth_pkg::stereo_sample_t audio_out,
	output logic                      write_audio_out
);

	import synth_pkg::*;

	logic [7:0]                   byte_data;
	logic                         byte_valid;
	voice_slots_t                 slots;
	sample_t [NUM_VOICES-1:0]     waves;

	// Scan code bytes from the keyboard
	ps2_rx u_ps2_rx (
		.CLOCK_50   (CLOCK_50),
		.arst_n     (arst_n),
		.ps2_clk    (ps2_clk),
		.ps2_dat    (ps2_dat),
		.byte_data  (byte_data),
		.byte_valid (byte_valid)
	);

	key_tracker u_key_tracker (
		.CLOCK_50   (CLOCK_50),
		.arst_n     (arst_n),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.slots      (slots)
	);

	// One square wave per slot
	for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
		tone_voice u_tone_voice (
			.CLOCK_50 (CLOCK_50),
			.arst_n   (arst_n),
			.slot     (slots[v]),
			.wave     (waves[v])
		);
	end

	sample_mixer u_sample_mixer (
		.CLOCK_50           (CLOCK_50),
		.arst_n             (arst_n),
		.tone_sel           (tone_sel),
		.waves              (waves),
		.audio_in           (audio_in),
		.audio_in_available (audio_in_available),
		.audio_out_allowed  (audio_out_allowed),
		.read_audio_in      (read_audio_in),
		.audio_out          (audio_out),
		.write_audio_out    (write_audio_out)
	);

endmodule

`default_nettype wire

/* hdl/ps2_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
	input  wire        CLOCK_50,
	input  wire        arst_n,
	input  wire        ps2_clk,
	input  wire        ps2_dat,
	output logic [7:0] byte_data,
	output logic       byte_valid
);

	// Two sync stages plus one history stage on the clock line
	logic [2:0] clk_sync;
	logic [1:0] dat_sync;
	logic       clk_fall;
	logic       dat_bit;
	// Frame position, 0 waits for the start bit
	logic [3:0] bit_cnt;
	logic [7:0] shift;
	logic       parity_bit;

	assign clk_fall = clk_sync[2] & ~clk_sync[1];
	assign dat_bit  = dat_sync[1];

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			// Lines idle high
			clk_sync   <= '1;
			dat_sync   <= '1;
			bit_cnt    <= '0;
			byte_valid <= 1'b0;
		end else begin
			clk_sync   <= {clk_sync[1:0], ps2_clk};
			dat_sync   <= {dat_sync[0], ps2_dat};
			byte_valid <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == 4'd0) begin
					// Start bit must be low
					if (!dat_bit)
						bit_cnt <= 4'd1;
				end else if (bit_cnt == 4'd10) begin
					// Stop high and odd parity over data plus parity bit
					byte_valid <= dat_bit & (^{shift, parity_bit});
					bit_cnt    <= 4'd0;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	// Data path
	always_ff @(posedge CLOCK_50) begin
		if (clk_fall) begin
			// LSB arrives first
			if (bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
				shift <= {dat_bit, shift[7:1]};
			if (bit_cnt == 4'd9)
				parity_bit <= dat_bit;
			if (bit_cnt == 4'd10)
				byte_data <= shift;
		end
	end

	// Frames are at least 11 PS/2 clocks apart
	a_valid_single: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		byte_valid |=> !byte_valid);

endmodule

`default_nettype wire

/* hdl/sample_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_mixer (
	input  wire                       CLOCK_50,
	input  wire                       arst_n,
	input  wire [3:0]                 tone_sel,
	input  wire synth_pkg::sample_t [synth_pkg::NUM_VOICES-1:0] waves,
	input  wire synth_pkg::stereo_sample_t audio_in,
	input  wire                       audio_in_available,
	input  wire                       audio_out_allowed,
	output logic                      read_audio_in,
	output synth_pkg::stereo_sample_t audio_out,
	output logic                      write_audio_out
);

	import synth_pkg::*;

	logic [18:0]        tone_cnt;
	logic [18:0]        tone_limit;
	logic               tone_phase;
	sample_t            tone;
	// Two guard bits cover the sum of three full scale waves
	logic signed [17:0] voice_sum;
	logic signed [17:0] voice_avg;
	sample_t            voice_mix;
	logic               xfer;

	// tone_sel * 32768 + TONE_BASE
	assign tone_limit = {tone_sel, 15'(TONE_BASE)};

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			tone_cnt   <= '0;
			tone_phase <= 1'b0;
		end else if (tone_sel == 4'd0) begin
			// Parked while the tone is off
			tone_cnt   <= '0;
			tone_phase <= 1'b0;
		end else if (tone_cnt == tone_limit) begin
			tone_cnt   <= '0;
			tone_phase <= ~tone_phase;
		end else begin
			tone_cnt <= tone_cnt + 19'd1;
		end
	end

	assign tone = (tone_sel == 4'd0) ? sample_t'(0) : (tone_phase ? -VOICE_AMP : VOICE_AMP);

	// Signed average, division truncates toward zero
	always_comb begin
		voice_sum = '0;
		for (int i = 0; i < NUM_VOICES; i++)
			voice_sum = voice_sum + 18'(waves[i]);
		voice_avg = voice_sum / 18'sd3;
		voice_mix = voice_avg[15:0];
	end

	// Same cycle handshake on both sides
	assign xfer            = audio_in_available & audio_out_allowed;
	assign read_audio_in   = xfer;
	assign write_audio_out = xfer;

	// Sums wrap at 16 bits
	assign audio_out.left  = audio_in.left + tone + voice_mix;
	assign audio_out.right = audio_in.right + tone + voice_mix;

	a_write_has_input: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		write_audio_out |-> audio_in_available);

endmodule

`default_nettype wire

/* hdl/synth_pkg.sv */
`default_nettype none

package synth_pkg;

	// Voice count and amplitude shared by voices and test tone
	localparam int NUM_VOICES = 3;
	localparam logic signed [15:0] VOICE_AMP = 16'sh0FF0;
	// Low part of the test tone half period
	localparam int TONE_BASE = 300;
	// PS/2 set 2 break prefix
	localparam logic [7:0] BREAK_PREFIX = 8'hF0;

	// One signed audio sample
	typedef logic signed [15:0] sample_t;

	// Left and right channel pair
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_sample_t;

	// Held key per voice
	typedef struct packed {
		logic       active;
		logic [7:0] code;
	} voice_slot_t;

	typedef voice_slot_t [NUM_VOICES-1:0] voice_slots_t;

	// Half period in 50 MHz cycles for the home row keys
	// Zero means the code is not a note
	function automatic logic [16:0] note_half_period(input logic [7:0] code);
		logic [16:0] half;
		case (code)
			8'h1C:   half = 17'd95556; // A plays C4
			8'h1B:   half = 17'd85131; // S plays D4
			8'h23:   half = 17'd75843; // D plays E4
			8'h2B:   half = 17'd71586; // F plays F4
			8'h34:   half = 17'd63776; // G plays G4
			8'h33:   half = 17'd56818; // H plays A4
			8'h3B:   half = 17'd50619; // J plays B4
			default: half = 17'd0;
		endcase
		return half;
	endfunction

endpackage

`default_nettype wire

/* hdl/tone_voice.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_voice (
	input  wire                    CLOCK_50,
	input  wire                    arst_n,
	input  wire synth_pkg::voice_slot_t slot,
	output synth_pkg::sample_t     wave
);

	import synth_pkg::*;

	logic [16:0] half_period;
	logic [16:0] cnt;
	// High half of the square when set
	logic        phase;
	// Slot seen active on the previous edge
	logic        sounding;

	assign half_period = note_half_period(slot.code);

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			cnt      <= '0;
			phase    <= 1'b0;
			sounding <= 1'b0;
		end else if (!slot.active) begin
			// Next press starts on a fresh period
			cnt      <= '0;
			phase    <= 1'b0;
			sounding <= 1'b0;
		end else begin
			sounding <= 1'b1;
			if (cnt == half_period - 17'd1) begin
				cnt   <= '0;
				phase <= ~phase;
			end else begin
				cnt <= cnt + 17'd1;
			end
		end
	end

	// Silent until the slot has been active for one cycle
	always_comb begin
		if (!sounding)
			wave = '0;
		else if (phase)
			wave = -VOICE_AMP;
		else
			wave = VOICE_AMP;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_keyboard_synth \
	-f tb.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

/* tb.f */
hdl/synth_pkg.sv
hdl/ps2_rx.sv
hdl/key_tracker.sv
hdl/tone_voice.sv
hdl/sample_mixer.sv
hdl/keyboard_synth_top.sv
verif/tb_keyboard_synth.sv

/* verif/tb_keyboard_synth.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_keyboard_synth;

	import synth_pkg::*;

	// Clock cycles per PS/2 clock phase, 20 per bit
	localparam int PS2_HALF = 10;
	// Longest wait for one transfer
	localparam int WAIT_LIMIT = 64;
	// One voice of three averaged
	localparam sample_t ONE_VOICE = 16'sh0550;

	logic           CLOCK_50;
	logic           arst_n;
	logic           ps2_clk;
	logic           ps2_dat;
	logic [3:0]     tone_sel;
	stereo_sample_t audio_in;
	logic           audio_in_available;
	logic           audio_out_allowed;
	logic           read_audio_in;
	stereo_sample_t audio_out;
	logic           write_audio_out;
	int             errors;
	int             tests;

	keyboard_synth_top uut (
		.CLOCK_50           (CLOCK_50),
		.arst_n             (arst_n),
		.ps2_clk            (ps2_clk),
		.ps2_dat            (ps2_dat),
		.tone_sel           (tone_sel),
		.audio_in           (audio_in),
		.audio_in_available (audio_in_available),
		.audio_out_allowed  (audio_out_allowed),
		.read_audio_in      (read_audio_in),
		.audio_out          (audio_out),
		.write_audio_out    (write_audio_out)
	);

	always #2 CLOCK_50 = ~CLOCK_50;

	task automatic check_sample(input string name, input stereo_sample_t exp,
			input stereo_sample_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_slotless_diff(input string name, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int start);
		tests++;
		$display("Test %s finished with %0d errors", name, errors - start);
	endtask

	// One frame: start, data LSB first, odd parity, stop
	task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame;
		logic        par;
		par = ~^code;
		if (bad_parity)
			par = ~par;
		frame = {1'b1, par, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge CLOCK_50);
			ps2_clk <= 1'b1;
			ps2_dat <= frame[i];
			repeat (PS2_HALF) @(posedge CLOCK_50);
			ps2_clk <= 1'b0;
			repeat (PS2_HALF - 1) @(posedge CLOCK_50);
		end
		@(posedge CLOCK_50);
		ps2_clk <= 1'b1;
		ps2_dat <= 1'b1;
		// Idle gap lets the slot settle
		repeat (2 * PS2_HALF) @(posedge CLOCK_50);
	endtask

	// Output minus input once the transfer happens
	task automatic wait_write(input stereo_sample_t din, output stereo_sample_t diff);
		int   waited;
		logic done;
		waited = 0;
		done   = 1'b0;
		diff   = '0;
		while (!done && waited < WAIT_LIMIT) begin
			@(negedge CLOCK_50);
			if (write_audio_out) begin
				done = 1'b1;
				if (!read_audio_in) begin
					errors++;
					$display("read_audio_in is low in a cycle with write_audio_out high");
				end
				diff.left  = audio_out.left - din.left;
				diff.right = audio_out.right - din.right;
			end else begin
				waited++;
				@(posedge CLOCK_50);
			end
		end
		if (!done) begin
			errors++;
			$display("Timeout, write_audio_out stayed low for %0d cycles", WAIT_LIMIT);
		end
	endtask

	task automatic offer_sample(output stereo_sample_t diff);
		stereo_sample_t din;
		din.left  = 16'($urandom);
		din.right = 16'($urandom);
		@(posedge CLOCK_50);
		audio_in           <= din;
		audio_in_available <= 1'b1;
		wait_write(din, diff);
	endtask

	task automatic stop_samples();
		@(posedge CLOCK_50);
		audio_in_available <= 1'b0;
	endtask

	task automatic expect_passthrough(input string name, input int count);
		stereo_sample_t diff;
		for (int i = 0; i < count; i++) begin
			offer_sample(diff);
			check_sample(name, '0, diff);
		end
		stop_samples();
	endtask

	// Closest legal average of three sounding voices
	function automatic sample_t nearest_average(input sample_t d);
		sample_t mag;
		mag = (d > 16'sh0AA0 || d < -16'sh0AA0) ? VOICE_AMP : ONE_VOICE;
		return d[15] ? -mag : mag;
	endfunction

	task automatic test_passthrough();
		int start;
		start = errors;
		expect_passthrough("passthrough", 200);
		report_test("passthrough", start);
	endtask

	task automatic test_backpressure();
		int             start;
		stereo_sample_t din;
		stereo_sample_t diff;
		start     = errors;
		din.left  = 16'($urandom);
		din.right = 16'($urandom);
		@(posedge CLOCK_50);
		audio_out_allowed  <= 1'b0;
		audio_in           <= din;
		audio_in_available <= 1'b1;
		for (int i = 0; i < 12; i++) begin
			@(negedge CLOCK_50);
			if (read_audio_in || write_audio_out) begin
				errors++;
				$display("Transfer strobe high while audio_out_allowed is low");
			end
		end
		@(posedge CLOCK_50);
		audio_out_allowed <= 1'b1;
		wait_write(din, diff);
		check_sample("backpressure", '0, diff);
		stop_samples();
		report_test("backpressure", start);
	endtask

	task automatic test_tone();
		int             start;
		stereo_sample_t diff;
		stereo_sample_t exp;
		logic           seen_pos;
		logic           seen_neg;
		start    = errors;
		seen_pos = 1'b0;
		seen_neg = 1'b0;
		@(posedge CLOCK_50);
		tone_sel <= 4'd1;
		// Half period of 33069 cycles fits in the window
		for (int i = 0; i < 40000; i++) begin
			offer_sample(diff);
			exp.left  = diff.left[15] ? -VOICE_AMP : VOICE_AMP;
			exp.right = exp.left;
			check_sample("tone", exp, diff);
			if (diff.left == VOICE_AMP)
				seen_pos = 1'b1;
			if (diff.left == -VOICE_AMP)
				seen_neg = 1'b1;
		end
		stop_samples();
		if (!(seen_pos && seen_neg)) begin
			errors++;
			$display("Test tone did not show both signs in the window");
		end
		@(posedge CLOCK_50);
		tone_sel <= 4'd0;
		report_test("tone", start);
	endtask

	task automatic test_one_key();
		int             start;
		int             n;
		stereo_sample_t diff;
		sample_t        exp;
		logic           seen_pos;
		logic           seen_neg;
		start    = errors;
		seen_pos = 1'b0;
		seen_neg = 1'b0;
		n        = 0;
		send_ps2(8'h1C, 1'b0);
		// C4 half period is 95556 cycles
		while (!(seen_pos && seen_neg) && n < 250000) begin
			offer_sample(diff);
			n++;
			exp = (diff.left == 0) ? sample_t'(0) : (diff.left[15] ? -ONE_VOICE : ONE_VOICE);
			check_slotless_diff("one_key", exp, diff.left);
			check_slotless_diff("one_key", exp, diff.right);
			if (diff.left == ONE_VOICE)
				seen_pos = 1'b1;
			if (diff.left == -ONE_VOICE)
				seen_neg = 1'b1;
		end
		stop_samples();
		if (!(seen_pos && seen_neg)) begin
			errors++;
			$display("Timeout, voice for key 1C did not show both signs");
		end
		send_ps2(BREAK_PREFIX, 1'b0);
		send_ps2(8'h1C, 1'b0);
		expect_passthrough("one_key_release", 100);
		report_test("one_key", start);
	endtask

	task automatic test_full_slots();
		int             start;
		stereo_sample_t diff;
		start = errors;
		send_ps2(8'h1C, 1'b0);
		send_ps2(8'h1B, 1'b0);
		send_ps2(8'h23, 1'b0);
		// No slot left for this one
		send_ps2(8'h2B, 1'b0);
		for (int i = 0; i < 300; i++) begin
			offer_sample(diff);
			check_slotless_diff("full_slots", nearest_average(diff.left), diff.left);
			check_slotless_diff("full_slots", nearest_average(diff.right), diff.right);
		end
		stop_samples();
		send_ps2(BREAK_PREFIX, 1'b0);
		send_ps2(8'h1C, 1'b0);
		send_ps2(BREAK_PREFIX, 1'b0);
		send_ps2(8'h1B, 1'b0);
		send_ps2(BREAK_PREFIX, 1'b0);
		send_ps2(8'h23, 1'b0);
		expect_passthrough("full_slots_dropped", 100);
		report_test("full_slots", start);
	endtask

	task automatic test_bad_frames();
		int start;
		start = errors;
		send_ps2(8'h1C, 1'b1);
		// Q key is not a note
		send_ps2(8'h15, 1'b0);
		expect_passthrough("bad_frames", 200);
		report_test("bad_frames", start);
	endtask

	initial begin
		CLOCK_50           = 1'b0;
		arst_n             = 1'b0;
		ps2_clk            = 1'b1;
		ps2_dat            = 1'b1;
		tone_sel           = 4'd0;
		audio_in           = '0;
		audio_in_available = 1'b0;
		audio_out_allowed  = 1'b1;
		errors             = 0;
		tests              = 0;
		void'($urandom(32'h6aff));
		repeat (8) @(posedge CLOCK_50);
		arst_n <= 1'b1;
		repeat (4) @(posedge CLOCK_50);
		test_passthrough();
		test_backpressure();
		test_tone();
		test_one_key();
		test_full_slots();
		test_bad_frames();
		$display("Tests run %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
